/* hdl/tlb_pkg.sv */
`default_nettype none

package tlb_pkg;

    // Array geometry
    localparam int tlb_num     = 16;
    localparam int tlb_index_w = $clog2(tlb_num);

    // Field widths of one entry
    localparam int vpn2_w  = 19;
    localparam int asid_w  = 8;
    localparam int pfn_w   = 20;
    localparam int cattr_w = 3;

    typedef logic [tlb_index_w-1:0] tlb_index_t;

    // One physical page of the even/odd pair
    typedef struct packed {
        logic [pfn_w-1:0]   pfn;
        logic [cattr_w-1:0] c;
        logic               d;
        logic               v;
    } tlb_page_t;

    // page0 maps the even page, page1 the odd one
    typedef struct packed {
        logic [vpn2_w-1:0] vpn2;
        logic [asid_w-1:0] asid;
        logic              g;
        tlb_page_t         page0;
        tlb_page_t         page1;
    } tlb_entry_t;

    // Lookup request from one search port
    typedef struct packed {
        logic [vpn2_w-1:0] vpn2;
        logic              odd_page;
        logic [asid_w-1:0] asid;
    } tlb_search_req_t;

    // All zero on a miss
    typedef struct packed {
        logic       found;
        tlb_index_t index;
        tlb_page_t  page;
    } tlb_search_rsp_t;

    // Indexed write of a whole entry
    typedef struct packed {
        tlb_index_t index;
        tlb_entry_t entry;
    } tlb_write_t;

endpackage

`default_nettype wire

/* hdl/tlb_entry_array.sv */
`default_nettype none
`timescale 1ns/1ns

module tlb_entry_array (
    input  logic                                     clk,
    input  logic                                     arst_n,

    // Write port
    input  logic                                     we,
    input  tlb_pkg::tlb_write_t                      w_req,

    // Read port
    input  tlb_pkg::tlb_index_t                      r_index,
    output tlb_pkg::tlb_entry_t                      r_entry,

    // Full contents for the search ports
    output tlb_pkg::tlb_entry_t [tlb_pkg::tlb_num-1:0] entries
);

    import tlb_pkg::*;

    logic [tlb_num-1:0]           wr_sel;
    tlb_entry_t [tlb_num-1:0]     entry_q;

    // One-hot write select from the write index
    always_comb begin
        wr_sel                = '0;
        wr_sel[w_req.index]   = we;
    end

    // Entry storage
    generate
        for (genvar i = 0; i < tlb_num; i++) begin : g_entry
            always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                    entry_q[i] <= '0;
                end else if (wr_sel[i]) begin
                    entry_q[i] <= w_req.entry;
                end
            end
        end
    endgenerate

    // Combinational indexed read
    assign r_entry = entry_q[r_index];

    assign entries = entry_q;

endmodule

`default_nettype wire

/* hdl/tlb_lookup.sv */
`default_nettype none
`timescale 1ns/1ns

module tlb_lookup (
    input  tlb_pkg::tlb_entry_t [tlb_pkg::tlb_num-1:0] entries,
    input  tlb_pkg::tlb_search_req_t                   req,
    output tlb_pkg::tlb_search_rsp_t                   rsp
);

    import tlb_pkg::*;

    logic [tlb_num-1:0]       vpn2_hit;
    logic [tlb_num-1:0]       asid_hit;
    logic [tlb_num-1:0]       match;

    tlb_index_t [tlb_num-1:0] index_term;
    tlb_page_t  [tlb_num-1:0] sel_page;
    tlb_page_t  [tlb_num-1:0] page_term;

    tlb_index_t               index_or;
    tlb_page_t                page_or;

    // Associative compare against every entry
    generate
        for (genvar i = 0; i < tlb_num; i++) begin : g_match
            assign vpn2_hit[i] = (entries[i].vpn2 == req.vpn2);

            // Global entries ignore the address-space id
            assign asid_hit[i] = (entries[i].asid == req.asid) || entries[i].g;

            assign match[i]    = vpn2_hit[i] && asid_hit[i];
        end
    endgenerate

    // Per-entry terms stay zero unless the entry matches
    generate
        for (genvar i = 0; i < tlb_num; i++) begin : g_term
            assign index_term[i] = match[i] ? tlb_index_t'(i) : '0;

            // Even or odd half of the page pair
            assign sel_page[i]   = req.odd_page ? entries[i].page1 : entries[i].page0;

            assign page_term[i]  = match[i] ? sel_page[i] : '0;
        end
    endgenerate

    // OR merge; at most one term is non-zero for a well-formed TLB
    always_comb begin
        index_or = '0;
        page_or  = '0;
        for (int i = 0; i < tlb_num; i++) begin
            index_or = index_or | index_term[i];
            page_or  = tlb_page_t'(page_or | page_term[i]);
        end
    end

    assign rsp.found = |match;
    assign rsp.index = index_or;
    assign rsp.page  = page_or;

endmodule

`default_nettype wire

/* hdl/tlb_top.sv */
`default_nettype none
`timescale 1ns/1ns

module tlb_top (
    input  logic                     clk,
    input  logic                     arst_n,

    // Write port
    input  logic                     we,
    input  tlb_pkg::tlb_write_t      w_req,

    // Read port
    input  tlb_pkg::tlb_index_t      r_index,
    output tlb_pkg::tlb_entry_t      r_entry,

    // Search port 0
    input  tlb_pkg::tlb_search_req_t s0_req,
    output tlb_pkg::tlb_search_rsp_t s0_rsp,

    // Search port 1
    input  tlb_pkg::tlb_search_req_t s1_req,
    output tlb_pkg::tlb_search_rsp_t s1_rsp
);

    import tlb_pkg::*;

    tlb_entry_t [tlb_num-1:0] entries;

    // Storage with write and read ports
    tlb_entry_array u_entries (
        .clk     (clk),
        .arst_n  (arst_n),
        .we      (we),
        .w_req   (w_req),
        .r_index (r_index),
        .r_entry (r_entry),
        .entries (entries)
    );

    // Two independent search ports on the same contents
    tlb_lookup u_search0 (
        .entries (entries),
        .req     (s0_req),
        .rsp     (s0_rsp)
    );

    tlb_lookup u_search1 (
        .entries (entries),
        .req     (s1_req),
        .rsp     (s1_rsp)
    );

endmodule

`default_nettype wire

/* verification/tlb_top_tb.sv */
`default_nettype none
`timescale 1ns/1ns

module tlb_top_tb;

    import tlb_pkg::*;

    logic            clk = 1'b0;
    logic            arst_n;
    logic            we;
    tlb_write_t      w_req;
    tlb_index_t      r_index;
    tlb_entry_t      r_entry;
    tlb_search_req_t s0_req;
    tlb_search_rsp_t s0_rsp;
    tlb_search_req_t s1_req;
    tlb_search_rsp_t s1_rsp;

    // Fields of the current data line
    logic [31:0]     fld [0:11];

    // Expected results for the current cycle
    logic            r_pending;
    tlb_index_t      r_exp_index;
    tlb_entry_t      r_exp;
    logic [1:0]      s_pending;
    tlb_search_rsp_t s_exp [0:1];

    string           grp_name;
    logic            grp_active;
    int              grp_checks;
    int              grp_errors;
    int              total_checks;
    int              total_errors;
    int              tests_passed;
    int              tests_failed;
    logic            timed_out;
    int              seed = 32'h54c76f36;

    tlb_top tlb_top_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .we      (we),
        .w_req   (w_req),
        .r_index (r_index),
        .r_entry (r_entry),
        .s0_req  (s0_req),
        .s0_rsp  (s0_rsp),
        .s1_req  (s1_req),
        .s1_rsp  (s1_rsp)
    );

    always #2 clk = ~clk;

    // Samples clk between its toggles
    task automatic wait_rise();
        logic prev;
        logic rose;
        int   polls;
        rose  = 1'b0;
        polls = 0;
        prev  = clk;
        while (!rose && polls < 8) begin
            #2;
            polls++;
            if (prev == 1'b0 && clk == 1'b1) begin
                rose = 1'b1;
            end
            prev = clk;
        end
        if (!rose) begin
            timed_out = 1'b1;
        end
    endtask

    function automatic string strip_eol(input string s);
        string t;
        t = s;
        while (t.len() > 0 && (t.getc(t.len() - 1) == 8'h0a || t.getc(t.len() - 1) == 8'h0d)) begin
            t = t.substr(0, t.len() - 2);
        end
        return t;
    endfunction

    function automatic tlb_page_t page_from_fields(input int base);
        tlb_page_t p;
        p.pfn = fld[base][pfn_w-1:0];
        p.c   = fld[base + 1][cattr_w-1:0];
        p.d   = fld[base + 2][0];
        p.v   = fld[base + 3][0];
        return p;
    endfunction

    function automatic tlb_entry_t entry_from_fields();
        tlb_entry_t e;
        e.vpn2  = fld[1][vpn2_w-1:0];
        e.asid  = fld[2][asid_w-1:0];
        e.g     = fld[3][0];
        e.page0 = page_from_fields(4);
        e.page1 = page_from_fields(8);
        return e;
    endfunction

    task automatic note_error(input string msg);
        $display("%s", msg);
        grp_errors++;
    endtask

    task automatic finish_group();
        if (grp_active) begin
            $display("test %s: %s (%0d checks, %0d errors)", grp_name,
                     (grp_errors == 0) ? "passed" : "failed", grp_checks, grp_errors);
            if (grp_errors == 0) begin
                tests_passed++;
            end else begin
                tests_failed++;
            end
        end
        total_checks += grp_checks;
        total_errors += grp_errors;
        grp_checks   = 0;
        grp_errors   = 0;
        grp_active   = 1'b0;
    endtask

    task automatic check_rsp(input int port, input tlb_search_rsp_t exp);
        tlb_search_rsp_t act;
        act = (port == 0) ? s0_rsp : s1_rsp;
        grp_checks++;
        if (act !== exp) begin
            $display("Mismatch s%0d_rsp: expected %h, actual %h", port, exp, act);
            grp_errors++;
        end
    endtask

    // Check just before the next edge, then move to the next drive point
    task automatic end_cycle();
        #2;
        if (r_pending) begin
            grp_checks++;
            if (r_entry !== r_exp) begin
                $display("Mismatch r_entry[%h]: expected %h, actual %h",
                         r_exp_index, r_exp, r_entry);
                grp_errors++;
            end
        end
        for (int p = 0; p < 2; p++) begin
            if (s_pending[p]) begin
                check_rsp(p, s_exp[p]);
            end
        end
        r_pending = 1'b0;
        s_pending = '0;
        wait_rise();
        we = 1'b0;
    endtask

    task automatic apply_search();
        tlb_search_req_t req;
        tlb_search_rsp_t exp;
        logic [31:0]     rnd;
        req.vpn2     = fld[1][vpn2_w-1:0];
        req.odd_page = fld[2][0];
        // Out-of-range asid in the data marks a don't-care on a global entry
        if (fld[3] > 32'hff) begin
            rnd      = $random(seed);
            req.asid = rnd[asid_w-1:0];
        end else begin
            req.asid = fld[3][asid_w-1:0];
        end
        exp.found = fld[4][0];
        exp.index = tlb_index_t'(fld[5]);
        exp.page  = page_from_fields(6);
        if (fld[0] == 32'h0) begin
            s0_req       = req;
            s_exp[0]     = exp;
            s_pending[0] = 1'b1;
        end else if (fld[0] == 32'h1) begin
            s1_req       = req;
            s_exp[1]     = exp;
            s_pending[1] = 1'b1;
        end else begin
            note_error("search line names a port other than 0 or 1");
        end
    endtask

    task automatic process_line(input string raw);
        string line;
        string rest;
        byte   op;
        int    n;
        line = strip_eol(raw);
        if (line.len() > 0) begin
            op   = line.getc(0);
            rest = line.substr(1, line.len() - 1);
            if (op == "T") begin
                finish_group();
                grp_name   = line.substr(2, line.len() - 1);
                grp_active = 1'b1;
            end else if (op == "N") begin
                end_cycle();
            end else if (op == "W" || op == "R") begin
                n = $sscanf(rest, "%h %h %h %h %h %h %h %h %h %h %h %h",
                            fld[0], fld[1], fld[2], fld[3], fld[4], fld[5],
                            fld[6], fld[7], fld[8], fld[9], fld[10], fld[11]);
                if (n != 12) begin
                    note_error({"malformed data line: ", line});
                end else if (op == "W") begin
                    we          = 1'b1;
                    w_req.index = tlb_index_t'(fld[0]);
                    w_req.entry = entry_from_fields();
                end else begin
                    r_index     = tlb_index_t'(fld[0]);
                    r_exp_index = tlb_index_t'(fld[0]);
                    r_exp       = entry_from_fields();
                    r_pending   = 1'b1;
                end
            end else if (op == "S") begin
                n = $sscanf(rest, "%h %h %h %h %h %h %h %h %h %h",
                            fld[0], fld[1], fld[2], fld[3], fld[4],
                            fld[5], fld[6], fld[7], fld[8], fld[9]);
                if (n != 10) begin
                    note_error({"malformed data line: ", line});
                end else begin
                    apply_search();
                end
            end else if (op != "#" && op != " ") begin
                note_error({"unknown operation in data line: ", line});
            end
        end
    endtask

    initial begin
        int    fd;
        int    n;
        int    cycles;
        string raw;
        arst_n       = 1'b0;
        we           = 1'b0;
        w_req        = '0;
        r_index      = '0;
        s0_req       = '0;
        s1_req       = '0;
        r_pending    = 1'b0;
        s_pending    = '0;
        grp_active   = 1'b0;
        grp_name     = "";
        grp_checks   = 0;
        grp_errors   = 0;
        total_checks = 0;
        total_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        timed_out    = 1'b0;

        #1;
        cycles = 0;
        while (cycles < 10 && !timed_out) begin
            wait_rise();
            cycles++;
        end
        arst_n = 1'b1;

        if (!timed_out) begin
            fd = $fopen("verification/tlb_testdata.txt", "r");
            if (fd == 0) begin
                note_error("could not open the test data file");
            end else begin
                while (!$feof(fd) && !timed_out) begin
                    raw = "";
                    n   = $fgets(raw, fd);
                    if (n > 0) begin
                        process_line(raw);
                    end
                end
                $fclose(fd);
            end
        end
        finish_group();

        if (timed_out) begin
            $display("timeout while waiting for a rising clock edge");
        end
        $display("tests: %0d passed, %0d failed; checks: %0d run, %0d errors",
                 tests_passed, tests_failed, total_checks, total_errors);
        if (total_errors == 0 && !timed_out && total_checks > 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/tlb_testdata.txt */
# W idx vpn2 asid g pfn0 c0 d0 v0 pfn1 c1 d1 v1 / R idx + expected entry, same columns
# S port vpn2 odd asid found index pfn c d v (asid FFF = random) / T group / N next cycle
T reset
R 0 0 0 0 0 0 0 0 0 0 0 0
N
R 5 0 0 0 0 0 0 0 0 0 0 0
N
R F 0 0 0 0 0 0 0 0 0 0 0 0
N
T write_read
W 1 12345 2A 0 ABCDE 3 1 1 12340 2 0 1
N
W 6 7F00F 05 0 00100 5 1 0 00101 5 1 1
R 1 12345 2A 0 ABCDE 3 1 1 12340 2 0 1
N
W 9 00ABC 11 1 55555 7 0 1 66666 6 1 1
R 6 7F00F 05 0 00100 5 1 0 00101 5 1 1
N
R 9 00ABC 11 1 55555 7 0 1 66666 6 1 1
N
W 6 3C3C3 44 0 FEDCB 1 1 1 BCDEF 0 0 1
R 6 7F00F 05 0 00100 5 1 0 00101 5 1 1
N
R 6 3C3C3 44 0 FEDCB 1 1 1 BCDEF 0 0 1
N
T search_even_odd
S 0 12345 0 2A 1 1 ABCDE 3 1 1
S 1 12345 1 2A 1 1 12340 2 0 1
N
S 0 3C3C3 1 44 1 6 BCDEF 0 0 1
S 1 3C3C3 0 44 1 6 FEDCB 1 1 1
N
T global_asid
S 0 00ABC 0 FFF 1 9 55555 7 0 1
S 1 00ABC 1 FFF 1 9 66666 6 1 1
N
S 0 00ABC 1 11 1 9 66666 6 1 1
S 1 12345 0 2B 0 0 0 0 0 0
N
S 0 3C3C3 0 45 0 0 0 0 0 0
S 1 7F00F 0 05 0 0 0 0 0 0
N
T dual_port
W C 2468A 77 0 13579 4 1 1 2468A 3 0 0
S 0 12345 1 2A 1 1 12340 2 0 1
S 1 00ABC 0 33 1 9 55555 7 0 1
N
S 0 2468A 0 77 1 C 13579 4 1 1
S 1 2468A 1 77 1 C 2468A 3 0 0
R C 2468A 77 0 13579 4 1 1 2468A 3 0 0
N

/* tlb.f */
hdl/tlb_pkg.sv
hdl/tlb_entry_array.sv
hdl/tlb_lookup.sv
hdl/tlb_top.sv
verification/tlb_top_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --timing
TOP       = tlb_top_tb
FILELIST  = tlb.f
OBJ_DIR   = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)
